/* hw/trace_pkg.sv */
package trace_pkg;

	// ********************
	// snapshot geometry
	// ********************

	localparam int lane_count = 48;
	localparam int lanes_per_frame = 16;
	localparam int error_bits = 8;

	// only the middle lanes carry useful sliding-detector flags
	localparam int sd_first_lane = 8;
	localparam int sd_lane_count = 24;

	// ********************
	// memory and readback
	// ********************

	localparam int word_bits = 144;
	localparam int words_per_capture = 4;
	localparam int chunk_bits = 32;
	localparam int chunks_per_word = 5;

	typedef logic signed [error_bits-1:0] error_sample_t;

	// lane 0 sits in the lowest position of every field
	typedef struct packed {
		error_sample_t [lane_count-1:0] errors;
		logic [lane_count-1:0] prbs_flags;
		logic [lane_count-1:0] bitstream;
		logic [lane_count-1:0][1:0] sd_flags;
	} lane_capture_t;

	// read is a level, enable is a one-cycle pulse
	typedef struct packed {
		logic read;
		logic enable;
		logic [2:0] chunk_sel;
	} trace_dbg_ctrl_t;

	typedef enum logic [1:0] {
		idle_ready,
		storing,
		read_back
	} trace_state_t;

endpackage

/* hw/trace_frame_packer.sv */
`timescale 1ns/10ps

module trace_frame_packer (
	input logic clk,
	input logic rstb,
	input logic latch_capture,
	input trace_pkg::lane_capture_t lanes,
	input logic [1:0] word_sel,
	output logic [trace_pkg::word_bits-1:0] frame_word
);

	localparam logic [1:0] flag_word = 2'(trace_pkg::words_per_capture - 1);
	localparam int flag_base = 2 * trace_pkg::lane_count;

	trace_pkg::lane_capture_t snap;
	logic [trace_pkg::word_bits-1:0] error_word;
	logic [trace_pkg::word_bits-1:0] flag_word_bits;

	// snapshot held for the four write cycles
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			snap <= '0;
		end else if (latch_capture) begin
			snap <= lanes;
		end
	end

	// ********************
	// error words 0 to 2
	// ********************

	// group g covers lanes 16g to 16g+15, upper 16 bits stay zero
	always_comb begin
		error_word = '0;
		for (int j = 0; j < trace_pkg::lanes_per_frame; j++) begin
			error_word[trace_pkg::error_bits*j +: trace_pkg::error_bits] =
				snap.errors[trace_pkg::lanes_per_frame*word_sel + j];
		end
	end

	// ********************
	// flag word 3
	// ********************

	always_comb begin
		flag_word_bits = '0;
		flag_word_bits[trace_pkg::lane_count-1:0] = snap.prbs_flags;
		flag_word_bits[flag_base-1:trace_pkg::lane_count] = snap.bitstream;
		// outer sliding-detector lanes are dropped
		for (int k = 0; k < trace_pkg::sd_lane_count; k++) begin
			flag_word_bits[flag_base + 2*k +: 2] = snap.sd_flags[trace_pkg::sd_first_lane + k];
		end
	end

	assign frame_word = (word_sel == flag_word) ? flag_word_bits : error_word;

endmodule

/* hw/trace_store_ctrl.sv */
`timescale 1ns/10ps

module trace_store_ctrl #(
	parameter int addr_width = 12
) (
	input logic clk,
	input logic rstb,
	input logic trigger,
	input trace_pkg::trace_dbg_ctrl_t dbg_ctrl,
	output logic latch_capture,
	output logic [1:0] word_sel,
	output logic [addr_width-1:0] write_addr,
	output logic web,
	output trace_pkg::trace_state_t state,
	output logic trace_done
);

	localparam logic [addr_width-1:0] last_addr = '1;
	localparam logic [1:0] last_word = 2'(trace_pkg::words_per_capture - 1);

	trace_pkg::trace_state_t next_state;
	logic [1:0] word_cnt;
	logic word_last;
	logic mem_full;
	logic chain_capture;

	assign word_last = (word_cnt == last_word);

	// captures are address aligned, so the full check only matters on word 3
	assign mem_full = word_last && (write_addr == last_addr);

	// back-to-back capture, a trigger in the word-3 cycle
	assign chain_capture = (state == trace_pkg::storing) && word_last && !mem_full && trigger;

	// ********************
	// next state
	// ********************

	always_comb begin
		next_state = state;
		case (state)
			trace_pkg::idle_ready: begin
				if (trigger) begin
					next_state = trace_pkg::storing;
				end else if (dbg_ctrl.read) begin
					next_state = trace_pkg::read_back;
				end
			end
			trace_pkg::storing: begin
				if (word_last) begin
					if (mem_full) begin
						next_state = trace_pkg::read_back;
					end else if (trigger) begin
						next_state = trace_pkg::storing;
					end else if (dbg_ctrl.read) begin
						next_state = trace_pkg::read_back;
					end else begin
						next_state = trace_pkg::idle_ready;
					end
				end
			end
			trace_pkg::read_back: begin
				// triggers are ignored until re-armed
				if (dbg_ctrl.enable) begin
					next_state = trace_pkg::idle_ready;
				end
			end
			default: next_state = trace_pkg::idle_ready;
		endcase
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			state <= trace_pkg::idle_ready;
			word_cnt <= '0;
			write_addr <= '0;
		end else begin
			state <= next_state;
			if (state == trace_pkg::storing) begin
				word_cnt <= word_cnt + 2'd1;
				// stop at the last address once the memory is full
				if (!mem_full) begin
					write_addr <= write_addr + 1'b1;
				end
			end else begin
				word_cnt <= '0;
				if (state == trace_pkg::read_back && dbg_ctrl.enable) begin
					write_addr <= '0;
				end
			end
		end
	end

	assign latch_capture = (state == trace_pkg::idle_ready && trigger) || chain_capture;
	assign word_sel = word_cnt;
	assign web = (state != trace_pkg::storing);
	assign trace_done = (state == trace_pkg::read_back);

endmodule

/* hw/trace_sram.sv */
`timescale 1ns/10ps

module trace_sram #(
	parameter int addr_width = 12,
	parameter int data_bits = 144
) (
	input logic clk,
	input logic web,
	input logic [addr_width-1:0] addr,
	input logic [data_bits-1:0] wdata,
	output logic [data_bits-1:0] rdata
);

	localparam int depth = 2 ** addr_width;

	logic [data_bits-1:0] mem [depth];

	// single port, write when web is low, otherwise read
	always_ff @(posedge clk) begin
		if (!web) begin
			mem[addr] <= wdata;
		end else begin
			rdata <= mem[addr];
		end
	end

endmodule

/* hw/trace_readout.sv */
`timescale 1ns/10ps

module trace_readout (
	input logic clk,
	input logic rstb,
	input logic [trace_pkg::word_bits-1:0] rdata,
	input logic [2:0] chunk_sel,
	output logic [trace_pkg::chunk_bits-1:0] dbg_data
);

	localparam int last_chunk = trace_pkg::chunks_per_word - 1;
	localparam int tail_bits = trace_pkg::word_bits - trace_pkg::chunk_bits*last_chunk;

	logic [2:0] sel_q;
	logic [trace_pkg::chunk_bits-1:0] chunks [trace_pkg::chunks_per_word];
	logic [trace_pkg::chunk_bits-1:0] chunk_next;

	// full chunks from the bottom of the word
	for (genvar c = 0; c < last_chunk; c++) begin : g_chunk
		assign chunks[c] = rdata[trace_pkg::chunk_bits*c +: trace_pkg::chunk_bits];
	end

	// top 16 bits, left aligned
	assign chunks[last_chunk] = {rdata[trace_pkg::word_bits-1 -: tail_bits],
		{(trace_pkg::chunk_bits - tail_bits){1'b0}}};

	always_comb begin
		chunk_next = '0;
		if (sel_q <= 3'(last_chunk)) begin
			chunk_next = chunks[sel_q];
		end
	end

	// sel_q lines the selection up with the memory's registered read
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			sel_q <= '0;
			dbg_data <= '0;
		end else begin
			sel_q <= chunk_sel;
			dbg_data <= chunk_next;
		end
	end

endmodule

/* hw/error_trace_top.sv */
`timescale 1ns/10ps

module error_trace_top #(
	parameter int addr_width = 12
) (
	input logic clk,
	input logic rstb,
	input logic trigger,
	input trace_pkg::lane_capture_t lanes,
	input trace_pkg::trace_dbg_ctrl_t dbg_ctrl,
	input logic [addr_width-1:0] dbg_addr,
	output logic [trace_pkg::chunk_bits-1:0] dbg_data,
	output logic trace_done
);

	logic latch_capture;
	logic [1:0] word_sel;
	logic [addr_width-1:0] write_addr;
	logic [addr_width-1:0] mem_addr;
	logic web;
	trace_pkg::trace_state_t state;
	logic [trace_pkg::word_bits-1:0] frame_word;
	logic [trace_pkg::word_bits-1:0] rdata;

	// ********************
	// producer
	// ********************

	trace_frame_packer trace_frame_packer_inst (
		.clk(clk),
		.rstb(rstb),
		.latch_capture(latch_capture),
		.lanes(lanes),
		.word_sel(word_sel),
		.frame_word(frame_word)
	);

	trace_store_ctrl #(
		.addr_width(addr_width)
	) trace_store_ctrl_inst (
		.clk(clk),
		.rstb(rstb),
		.trigger(trigger),
		.dbg_ctrl(dbg_ctrl),
		.latch_capture(latch_capture),
		.word_sel(word_sel),
		.write_addr(write_addr),
		.web(web),
		.state(state),
		.trace_done(trace_done)
	);

	// ********************
	// buffer and consumer
	// ********************

	// debug port owns the address only while reading back
	assign mem_addr = (state == trace_pkg::read_back) ? dbg_addr : write_addr;

	trace_sram #(
		.addr_width(addr_width),
		.data_bits(trace_pkg::word_bits)
	) trace_sram_inst (
		.clk(clk),
		.web(web),
		.addr(mem_addr),
		.wdata(frame_word),
		.rdata(rdata)
	);

	trace_readout trace_readout_inst (
		.clk(clk),
		.rstb(rstb),
		.rdata(rdata),
		.chunk_sel(dbg_ctrl.chunk_sel),
		.dbg_data(dbg_data)
	);

endmodule

/* testbench/error_trace_tasks.svh */
// ********************
// cycle helpers
// ********************

// inputs change a few ns after the rising edge
task automatic next_cycle();
	@(posedge clk);
	#drive_delay;
endtask

task automatic compare_value(
	input logic [31:0] actual,
	input logic [31:0] expected,
	input string what
);
	check_count++;
	if (actual !== expected) begin
		error_count++;
		$display("** Error at time %0t: %s, got %h, expected %h", $time, what, actual,
			expected);
	end
endtask

task automatic wait_for_done(input string what);
	int cycles;
	cycles = 0;
	while (trace_done !== 1'b1 && cycles < done_timeout) begin
		next_cycle();
		cycles++;
	end
	if (trace_done !== 1'b1) begin
		timeout_count++;
		$display("timeout: trace_done did not rise during %s", what);
	end
endtask

// ********************
// model and port access
// ********************

task automatic record_capture(input trace_pkg::lane_capture_t cap);
	for (int w = 0; w < 4; w++) begin
		// a full memory takes no more words
		if (model_addr < mem_depth) begin
			if (model_addr < mem_model.size()) begin
				mem_model[model_addr] = layout_word(cap, w);
			end else begin
				mem_model.push_back(layout_word(cap, w));
			end
			model_addr++;
		end
	end
endtask

// one cycle for the memory, one for the readout register
task automatic read_chunk(input int addr, input logic [2:0] sel, output logic [31:0] data);
	dbg_addr = addr_width'(addr);
	dbg_ctrl.chunk_sel = sel;
	next_cycle();
	next_cycle();
	data = dbg_data;
endtask

task automatic verify_memory(input int first_addr, input int last_addr, input string what);
	logic [31:0] data;
	for (int a = first_addr; a <= last_addr; a++) begin
		for (int c = 0; c < 5; c++) begin
			read_chunk(a, 3'(c), data);
			compare_value(data, chunk_of_word(mem_model[a], c),
				$sformatf("%s, addr %0d chunk %0d", what, a, c));
		end
	end
endtask

// trigger for one cycle, then let the four writes pass
task automatic capture_once();
	trace_pkg::lane_capture_t cap;
	cap = fresh_snapshot();
	lanes = cap;
	trigger = 1'b1;
	next_cycle();
	trigger = 1'b0;
	// inverted lanes during the writes, only the latched snapshot may reach memory
	lanes = ~cap;
	record_capture(cap);
	repeat (4) next_cycle();
endtask

task automatic rearm();
	dbg_ctrl.read = 1'b0;
	dbg_ctrl.enable = 1'b1;
	next_cycle();
	dbg_ctrl.enable = 1'b0;
	model_addr = 0;
	compare_value(32'(trace_done), 32'd0, "trace_done after enable");
endtask

// ********************
// directed tests
// ********************

task automatic after_reset_values();
	compare_value(32'(trace_done), 32'd0, "trace_done after reset");
	compare_value(dbg_data, 32'd0, "dbg_data after reset");
endtask

task automatic single_capture_readback();
	capture_once();
	dbg_ctrl.read = 1'b1;
	wait_for_done("single capture");
	verify_memory(0, 3, "single capture");
endtask

task automatic gapped_captures_readback();
	rearm();
	for (int n = 0; n < 3; n++) begin
		capture_once();
		repeat (2) next_cycle();
	end
	dbg_ctrl.read = 1'b1;
	wait_for_done("gapped captures");
	verify_memory(0, 11, "gapped captures");
endtask

task automatic fill_memory_readback();
	trace_pkg::lane_capture_t cap;
	rearm();
	trigger = 1'b1;
	// a new snapshot lands in every word-3 cycle
	for (int k = 0; k < 20; k++) begin
		cap = fresh_snapshot();
		lanes = cap;
		record_capture(cap);
		next_cycle();
		// held trigger during words 0 to 2 must not reload the snapshot
		lanes = ~cap;
		repeat (3) next_cycle();
	end
	trigger = 1'b0;
	wait_for_done("memory fill");
	compare_value(32'(trace_done), 32'd1, "trace_done with full memory");
	verify_memory(0, mem_depth - 1, "full memory");
endtask

task automatic overwrite_after_enable();
	rearm();
	capture_once();
	dbg_ctrl.read = 1'b1;
	wait_for_done("capture after enable");
	verify_memory(0, mem_depth - 1, "after enable");
endtask

task automatic unused_chunk_selects();
	logic [31:0] data;
	for (int sel = 5; sel < 8; sel++) begin
		read_chunk(sel, 3'(sel), data);
		compare_value(data, 32'd0, $sformatf("chunk_sel %0d", sel));
	end
	dbg_ctrl.chunk_sel = 3'd0;
endtask

/* testbench/error_trace_tb.sv */
`timescale 1ns/10ps

module error_trace_tb;

	localparam int addr_width = 6;
	localparam int mem_depth = 2 ** addr_width;
	localparam int drive_delay = 5;
	localparam int done_timeout = 200;

	logic clk;
	logic rstb;
	logic trigger;
	trace_pkg::lane_capture_t lanes;
	trace_pkg::trace_dbg_ctrl_t dbg_ctrl;
	logic [addr_width-1:0] dbg_addr;
	logic [trace_pkg::chunk_bits-1:0] dbg_data;
	logic trace_done;

	logic [15:0] lfsr_state;
	int check_count;
	int error_count;
	int timeout_count;

	// expected memory contents, indexed by word address
	logic [trace_pkg::word_bits-1:0] mem_model [$];
	int model_addr;

	error_trace_top #(
		.addr_width(addr_width)
	) error_trace_top_inst (
		.clk(clk),
		.rstb(rstb),
		.trigger(trigger),
		.lanes(lanes),
		.dbg_ctrl(dbg_ctrl),
		.dbg_addr(dbg_addr),
		.dbg_data(dbg_data),
		.trace_done(trace_done)
	);

	always #50 clk = ~clk;

	// ********************
	// random source
	// ********************

	// galois form, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
	function automatic logic random_bit();
		logic out_bit;
		out_bit = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out_bit) begin
			lfsr_state = lfsr_state ^ 16'hb400;
		end
		return out_bit;
	endfunction

	// every field random, sd_flags on all 48 lanes too
	function automatic trace_pkg::lane_capture_t fresh_snapshot();
		logic [$bits(trace_pkg::lane_capture_t)-1:0] raw;
		for (int i = 0; i < $bits(raw); i++) begin
			raw[i] = random_bit();
		end
		return trace_pkg::lane_capture_t'(raw);
	endfunction

	// ********************
	// reference model
	// ********************

	function automatic logic [trace_pkg::word_bits-1:0] layout_word(
		input trace_pkg::lane_capture_t cap,
		input int w
	);
		logic [trace_pkg::word_bits-1:0] word;
		word = '0;
		if (w < 3) begin
			// lanes 16w to 16w+15, eight bits each
			for (int j = 0; j < 16; j++) begin
				word[8*j +: 8] = cap.errors[16*w + j];
			end
		end else begin
			word[47:0] = cap.prbs_flags;
			word[95:48] = cap.bitstream;
			for (int lane = 8; lane < 32; lane++) begin
				word[96 + 2*(lane - 8) +: 2] = cap.sd_flags[lane];
			end
		end
		return word;
	endfunction

	function automatic logic [31:0] chunk_of_word(
		input logic [trace_pkg::word_bits-1:0] word,
		input int c
	);
		case (c)
			0, 1, 2, 3: return word[32*c +: 32];
			4: return {word[143:128], 16'h0000};
			default: return 32'h0000_0000;
		endcase
	endfunction

	`include "error_trace_tasks.svh"

	initial begin
		clk = 1'b0;
		rstb = 1'b0;
		trigger = 1'b0;
		lanes = '0;
		dbg_ctrl = '0;
		dbg_addr = '0;
		lfsr_state = 16'd16114;
		check_count = 0;
		error_count = 0;
		timeout_count = 0;
		model_addr = 0;

		repeat (4) @(posedge clk);
		#drive_delay;
		rstb = 1'b1;

		after_reset_values();
		single_capture_readback();
		gapped_captures_readback();
		fill_memory_readback();
		overwrite_after_enable();
		unused_chunk_selects();

		$display("checks %0d, errors %0d, timeouts %0d", check_count, error_count,
			timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* build.f */
+incdir+testbench
hw/trace_pkg.sv
hw/trace_frame_packer.sv
hw/trace_store_ctrl.sv
hw/trace_sram.sv
hw/trace_readout.sv
hw/error_trace_top.sv
testbench/error_trace_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the error trace testbench with Verilator and runs it
set -e
set -o pipefail

cd "$(dirname "$0")"

log_file=sim.log

verilator --binary --timing -f build.f --top-module error_trace_tb \
	-Mdir obj_dir -o error_trace_sim

./obj_dir/error_trace_sim | tee "$log_file"

if grep -q -F '** FAIL **' "$log_file"; then
	echo "simulation failed, see $log_file"
	exit 1
fi

echo "simulation passed"
